// File: dv/ioCases.mem
// op_addr_wdata_expect_sel. op 0 read, 1 write, 2 read paired with next line, 3 fire, 4 no fire
// sel is the read kind, the checked output (F none) or the display index
0_300000_00_00_0
0_300001_00_00_1
0_320001_00_00_2
0_340000_00_00_3
0_380000_00_00_4
0_31FFFE_00_00_0
0_300081_00_00_F
0_3C0000_00_00_F
0_380001_00_00_F
1_300000_55_00_F
1_380001_2B_03_0
1_380001_3A_07_1
1_380011_05_05_2
1_380021_03_37_3
1_380021_06_3F_3
1_380021_07_3F_3
1_380021_FD_1F_3
1_3A0013_00_02_5
1_3A001F_00_82_5
1_3A0011_00_83_5
1_3A0003_00_81_5
1_3A001B_00_A1_5
1_380071_00_01_4
1_380075_00_05_4
1_380077_00_0D_4
1_380061_00_0C_4
1_380041_A5_00_F
3_380031_02_A5_1
4_380031_02_00_0
1_380041_3C_00_F
3_380031_03_04_0
4_380031_00_00_0
1_380041_96_00_F
3_380031_04_96_2
2_320001_00_00_2
0_340000_00_00_3
2_300001_00_00_1
0_380000_00_00_4
F_000000_00_00_0

// File: dv/neoIoTb.sv
`include "neoIo_macros.svh"

module neoIoTb;

	timeunit 1ns;
	timeprecision 100ps;

	import neoBusPkg::*;

	localparam int MAX_CASES = 64;
	localparam int PULSE     = `LATCH_PULSE_CYCLES;

	logic                  clk24M;
	logic                  rstN;
	logic                  accStb;
	ioAddr_t               busAddr;
	logic                  rw;
	logic [`IO_DATA_W-1:0] wdata;
	logic [`JOY_W-1:0]     p1In;
	logic [`JOY_W-1:0]     p2In;
	logic [`IO_DATA_W-1:0] dipSw;
	logic                  testBtn;
	logic [`IO_DATA_W-1:0] rdata;
	logic                  dtack;
	logic [2:0]            p1Out;
	logic [2:0]            p2Out;
	logic [2:0]            cardBank;
	logic [5:0]            slotN;
	logic [3:0]            elOut;
	logic [8:0]            ledOut1;
	logic [8:0]            ledOut2;
	logic                  counter1;
	logic                  counter2;
	logic                  lockout1;
	logic                  lockout2;
	logic                  shadow;
	logic                  vecN;
	logic                  cardWenN;
	logic                  cardWenB;
	logic                  regEnN;
	logic                  systemN;
	logic                  sramLockN;
	logic                  palBank;

	// Case word: op[47:44] addr[43:20] wdata[19:12] expect[11:4] sel[3:0]
	logic [47:0] cases [0:MAX_CASES-1];
	int          caseCount;
	int          caseIdx;
	logic [31:0] lfsrState;
	logic [7:0]  coinBits;
	logic [7:0]  sysFlags;

	// Latch contents packed in bit order
	assign coinBits = {4'h0, lockout2, lockout1, counter2, counter1};
	assign sysFlags = {palBank, sramLockN, systemN, regEnN, cardWenB, cardWenN, vecN, shadow};

	initial clk24M = 1'b0;
	always #5 clk24M = ~clk24M;

	neoIoTop u_dut (
		.clk24M    (clk24M),
		.rstN      (rstN),
		.accStb    (accStb),
		.busAddr   (busAddr),
		.rw        (rw),
		.wdata     (wdata),
		.p1In      (p1In),
		.p2In      (p2In),
		.dipSw     (dipSw),
		.testBtn   (testBtn),
		.rdata     (rdata),
		.dtack     (dtack),
		.p1Out     (p1Out),
		.p2Out     (p2Out),
		.cardBank  (cardBank),
		.slotN     (slotN),
		.elOut     (elOut),
		.ledOut1   (ledOut1),
		.ledOut2   (ledOut2),
		.counter1  (counter1),
		.counter2  (counter2),
		.lockout1  (lockout1),
		.lockout2  (lockout2),
		.shadow    (shadow),
		.vecN      (vecN),
		.cardWenN  (cardWenN),
		.cardWenB  (cardWenB),
		.regEnN    (regEnN),
		.systemN   (systemN),
		.sramLockN (sramLockN),
		.palBank   (palBank)
	);

	task automatic failRun(input string what);
		$display("%s", what);
		$display("FAIL: see errors above");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkValue(input string name, input logic [7:0] got, input logic [7:0] expVal);
		assert (got == expVal) else begin
			failRun($sformatf("** Error: %s got 0x%02h, expected 0x%02h in case %0d",
				name, got, expVal, caseIdx));
		end
	endtask

	// Galois LFSR, one step per bit handed out
	function automatic logic lfsrBit();
		logic outBit;
		outBit = lfsrState[0];
		lfsrState = lfsrState >> 1;
		if (outBit) begin
			lfsrState = lfsrState ^ 32'h80200003;
		end
		return outBit;
	endfunction

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			value = {value[30:0], lfsrBit()};
		end
		return value;
	endfunction

	task automatic randomizeInputs();
		logic [31:0] r;
		r = randBits(`JOY_W);
		p1In = r[`JOY_W-1:0];
		r = randBits(`JOY_W);
		p2In = r[`JOY_W-1:0];
		r = randBits(`IO_DATA_W);
		dipSw = r[`IO_DATA_W-1:0];
		r = randBits(1);
		testBtn = r[0];
	endtask

	// Read byte per target kind from the case file
	function automatic logic [7:0] expectedRead(input logic [3:0] kind);
		logic [7:0] value;
		case (kind)
			4'h0:    value = p1In[7:0];
			4'h1:    value = dipSw;
			4'h2:    value = {testBtn, 7'h7F};
			4'h3:    value = p2In[7:0];
			4'h4:    value = {4'hF, p2In[9:8], p1In[9:8]};
			default: value = 8'hFF;
		endcase
		return value;
	endfunction

	function automatic logic [7:0] outputView(input logic [3:0] sel);
		logic [7:0] value;
		case (sel)
			4'h0:    value = {5'b0, p1Out};
			4'h1:    value = {5'b0, p2Out};
			4'h2:    value = {5'b0, cardBank};
			4'h3:    value = {2'b0, slotN};
			4'h4:    value = coinBits;
			default: value = sysFlags;
		endcase
		return value;
	endfunction

	function automatic string outputName(input logic [3:0] sel);
		string name;
		case (sel)
			4'h0:    name = "p1Out";
			4'h1:    name = "p2Out";
			4'h2:    name = "cardBank";
			4'h3:    name = "slotN";
			4'h4:    name = "coin latch";
			default: name = "system latch";
		endcase
		return name;
	endfunction

	// Display 0 is EL, 1 and 2 are the LED digits
	function automatic logic displayClk(input logic [3:0] sel);
		return (sel == 4'h0) ? elOut[3] : ((sel == 4'h1) ? ledOut1[8] : ledOut2[8]);
	endfunction

	function automatic logic [7:0] displayData(input logic [3:0] sel);
		return (sel == 4'h0) ? {5'b0, elOut[2:0]} : ((sel == 4'h1) ? ledOut1[7:0] : ledOut2[7:0]);
	endfunction

	// Inputs change 1 ns past the rising edge
	task automatic stepCycle();
		@(posedge clk24M);
		#1;
	endtask

	task automatic driveAccess(input logic [47:0] entry);
		accStb  = 1'b1;
		busAddr = entry[43:20];
		rw      = (entry[47:44] == 4'h0) || (entry[47:44] == 4'h2);
		wdata   = entry[19:12];
	endtask

	task automatic waitAck(output int cycles);
		cycles = 0;
		while (!dtack && cycles < 8) begin
			stepCycle();
			cycles++;
		end
	endtask

	task automatic checkReset();
		checkValue("dtack", {7'b0, dtack}, 8'h00);
		checkValue("p1Out", {5'b0, p1Out}, 8'h00);
		checkValue("p2Out", {5'b0, p2Out}, 8'h00);
		checkValue("cardBank", {5'b0, cardBank}, 8'h00);
		checkValue("slotN", {2'b0, slotN}, 8'h3E);
		checkValue("elOut", {4'h0, elOut}, 8'h00);
		checkValue("ledOut1 clock", {7'b0, ledOut1[8]}, 8'h00);
		checkValue("ledOut1 data", ledOut1[7:0], 8'h00);
		checkValue("ledOut2 clock", {7'b0, ledOut2[8]}, 8'h00);
		checkValue("ledOut2 data", ledOut2[7:0], 8'h00);
		checkValue("coin latch", coinBits, 8'h00);
		checkValue("system latch", sysFlags, `SYSLATCH_RST);
	endtask

	// One access, reply expected two edges after the strobe
	task automatic runSingle(input logic [47:0] entry);
		int         cycles;
		logic       isRead;
		logic [7:0] expRd;
		isRead = (entry[47:44] == 4'h0);
		if (isRead) begin
			randomizeInputs();
		end
		driveAccess(entry);
		stepCycle();
		accStb = 1'b0;
		waitAck(cycles);
		// One edge already passed while the strobe was sampled
		assert (cycles == 1) else begin
			failRun($sformatf("dtack came %0d cycles after the strobe instead of 2",
				cycles + 1));
		end
		expRd = isRead ? expectedRead(entry[3:0]) : 8'hFF;
		checkValue("rdata", rdata, expRd);
		if (!isRead && entry[3:0] != 4'hF) begin
			checkValue(outputName(entry[3:0]), outputView(entry[3:0]), entry[11:4]);
		end
		stepCycle();
		assert (!dtack) else begin
			failRun("dtack stayed high for more than one cycle");
		end
	endtask

	// Two reads on consecutive cycles
	task automatic runPair(input logic [47:0] first, input logic [47:0] second);
		int cycles;
		randomizeInputs();
		driveAccess(first);
		stepCycle();
		driveAccess(second);
		stepCycle();
		accStb = 1'b0;
		// First reply is due right at this edge
		waitAck(cycles);
		assert (cycles == 0) else begin
			failRun("first dtack of a back-to-back pair came late");
		end
		checkValue("rdata", rdata, expectedRead(first[3:0]));
		stepCycle();
		assert (dtack) else begin
			failRun("second dtack of a back-to-back pair is missing");
		end
		checkValue("rdata", rdata, expectedRead(second[3:0]));
		stepCycle();
		assert (!dtack) else begin
			failRun("dtack stayed high after a back-to-back pair");
		end
	endtask

	// LEDLATCHES write, with or without a display pulse
	task automatic runDisplay(input logic [47:0] entry, input logic expectFire);
		int         cycles;
		int         highCycles;
		logic [3:0] sel;
		sel = entry[3:0];
		driveAccess(entry);
		stepCycle();
		accStb = 1'b0;
		if (expectFire) begin
			cycles = 0;
			while (!displayClk(sel) && cycles < 12) begin
				stepCycle();
				cycles++;
			end
			// Clock rises three edges after the strobe, one of them already passed
			assert (cycles == 2) else begin
				failRun($sformatf("display %0d clock rose %0d cycles after the strobe",
					sel, cycles + 1));
			end
			checkValue("display data", displayData(sel), entry[11:4]);
			highCycles = 0;
			while (displayClk(sel) && highCycles < PULSE + 8) begin
				stepCycle();
				highCycles++;
			end
			assert (highCycles == PULSE) else begin
				failRun($sformatf("display %0d clock was high for %0d cycles", sel, highCycles));
			end
		end else begin
			for (int i = 0; i < PULSE + 4; i++) begin
				stepCycle();
				assert (!elOut[3] && !ledOut1[8] && !ledOut2[8]) else begin
					failRun("a display clock fired without a 0 to 1 latch bit");
				end
			end
		end
	endtask

	// Limit scales with the number of cases
	initial begin : watchdog
		longint limitNs;
		wait (caseCount > 0);
		limitNs = longint'(caseCount + 20) * (6 + PULSE) * 10;
		#(limitNs);
		failRun($sformatf("Timeout: run still going after %0d ns", limitNs));
	end

	initial begin : mainSeq
		logic [47:0] entry;
		int          idx;
		rstN      = 1'b0;
		accStb    = 1'b0;
		busAddr   = '0;
		rw        = 1'b1;
		wdata     = '0;
		p1In      = '0;
		p2In      = '0;
		dipSw     = '0;
		testBtn   = 1'b0;
		caseIdx   = 0;
		caseCount = 0;
		lfsrState = 32'hc8a555d0;
		for (int i = 0; i < MAX_CASES; i++) begin
			cases[i] = '1;
		end
		$readmemh("dv/ioCases.mem", cases);
		// Op F marks the end of the list
		while (caseCount < MAX_CASES && cases[caseCount][47:44] != 4'hF) begin
			caseCount++;
		end
		repeat (2) @(posedge clk24M);
		#1;
		rstN = 1'b1;
		checkReset();
		idx = 0;
		while (idx < caseCount) begin
			caseIdx = idx;
			entry   = cases[idx];
			case (entry[47:44])
				4'h0, 4'h1: runSingle(entry);
				4'h2: begin
					runPair(entry, cases[idx + 1]);
					idx++;
				end
				4'h3: runDisplay(entry, 1'b1);
				4'h4: runDisplay(entry, 1'b0);
				default: failRun($sformatf("Case %0d has an unknown operation", idx));
			endcase
			idx++;
		end
		$display("PASS: all tests");
		$finish;
	end

endmodule

// File: logic/addrLatch.sv
module addrLatch #(
	parameter int               WIDTH   = 8,
	parameter logic [WIDTH-1:0] RST_VAL = '0
) (
	input  logic             clk24M,
	input  logic             rstN,
	input  logic             wrStb,
	input  logic [3:0]       wrAddr,
	output logic [WIDTH-1:0] q
);

	logic [2:0] bitSel;
	logic       bitVal;

	// A3..A1 pick the bit, A4 is the data
	assign bitSel = wrAddr[2:0];
	assign bitVal = wrAddr[3];

	// Behaves like a 74LS259 in addressable latch mode
	always_ff @(posedge clk24M or negedge rstN) begin
		if (!rstN) begin
			q <= RST_VAL;
		end else if (wrStb) begin
			// Indices past WIDTH hit nothing
			for (int i = 0; i < WIDTH; i++) begin
				if (bitSel == 3'(i)) begin
					q[i] <= bitVal;
				end
			end
		end
	end

endmodule

// File: logic/displayLatch.sv
`include "neoIo_macros.svh"

module displayLatch #(
	parameter type payloadT = logic [7:0]
) (
	input  logic    clk24M,
	input  logic    rstN,
	input  logic    fire,
	input  payloadT payload,
	output logic    latchClk,
	output payloadT data
);

	localparam int CNT_W = $clog2(`LATCH_PULSE_CYCLES + 1);

	logic [CNT_W-1:0] pulseCnt;

	// Clock high while cycles remain
	assign latchClk = (pulseCnt != '0);

	always_ff @(posedge clk24M or negedge rstN) begin
		if (!rstN) begin
			pulseCnt <= '0;
			data     <= '0;
		end else if (fire) begin
			// A new fire restarts the pulse with fresh data
			pulseCnt <= CNT_W'(`LATCH_PULSE_CYCLES);
			data     <= payload;
		end else if (pulseCnt != '0) begin
			pulseCnt <= pulseCnt - 1'b1;
		end
	end

endmodule

// File: logic/ioAddrDecode.sv
`include "neoIo_macros.svh"

module ioAddrDecode (
	input  logic                    clk24M,
	input  logic                    rstN,
	input  logic                    accStb,
	input  neoBusPkg::ioAddr_t      busAddr,
	input  logic                    rw,
	input  logic [`IO_DATA_W-1:0]   wdata,
	output logic                    selStb,
	output neoBusPkg::ioReg_t       selReg,
	output logic                    selRw,
	output logic [3:0]              selAddr,
	output logic [`IO_DATA_W-1:0]   selData,
	output logic                    sysLatchWr,
	output logic                    coinLatchWr
);

	import neoBusPkg::*;

	ioAddr_t masked;
	ioReg_t  nextReg;

	// Only A21..A17 and A0 take part in the window match
	assign masked = busAddr & 24'h3E0001;

	always_comb begin
		nextReg = regNone;
		if (rw) begin
			// Read side
			case (masked)
				24'h300000: nextReg = regP1Cnt;
				// 0x300081 is a different register, not modelled
				24'h300001: nextReg = busAddr[7] ? regNone : regDipSw;
				24'h320001: nextReg = regStatusA;
				24'h340000: nextReg = regP2Cnt;
				24'h380000: nextReg = regStatusB;
				default:    nextReg = regNone;
			endcase
		end else begin
			if (masked == 24'h380001) begin
				// nCOUNTOUT range wins over the bit-write group
				if (busAddr[6:5] == 2'b11) begin
					nextReg = regCoin;
				end else begin
					case (busAddr[6:4])
						3'd0:    nextReg = regPOutput;
						3'd1:    nextReg = regCrdBank;
						3'd2:    nextReg = regSlot;
						3'd3:    nextReg = regLedLatches;
						3'd4:    nextReg = regLedData;
						// RTC control lives here on the board
						default: nextReg = regNone;
					endcase
				end
			end else if (masked == 24'h3A0001) begin
				nextReg = regSysLatch;
			end
		end
	end

	// Strobes, one cycle after the CPU strobe
	always_ff @(posedge clk24M or negedge rstN) begin
		if (!rstN) begin
			selStb      <= 1'b0;
			sysLatchWr  <= 1'b0;
			coinLatchWr <= 1'b0;
		end else begin
			selStb      <= accStb;
			sysLatchWr  <= accStb && (nextReg == regSysLatch);
			coinLatchWr <= accStb && (nextReg == regCoin);
		end
	end

	// Access details, only meaningful alongside selStb
	always_ff @(posedge clk24M) begin
		if (accStb) begin
			selReg  <= nextReg;
			selRw   <= rw;
			selAddr <= busAddr[4:1];
			selData <= wdata;
		end
	end

endmodule

// File: logic/ioRegFile.sv
`include "neoIo_macros.svh"

module ioRegFile (
	input  logic                    clk24M,
	input  logic                    rstN,
	input  logic                    selStb,
	input  neoBusPkg::ioReg_t       selReg,
	input  logic                    selRw,
	input  logic [`IO_DATA_W-1:0]   selData,
	input  logic [`JOY_W-1:0]       p1In,
	input  logic [`JOY_W-1:0]       p2In,
	input  logic [`IO_DATA_W-1:0]   dipSw,
	input  logic                    testBtn,
	output logic [`IO_DATA_W-1:0]   rdata,
	output logic                    dtack,
	output logic [2:0]              p1Out,
	output logic [2:0]              p2Out,
	output logic [2:0]              cardBank,
	output logic [5:0]              slotN,
	output neoIoPkg::ledDigit_t     ledData,
	output logic [2:0]              latchFire
);

	import neoBusPkg::*;

	logic [2:0]            ledLatchQ;
	logic [`IO_DATA_W-1:0] readMux;
	logic                  wrStb;

	// Active-low slot select, 6 and 7 deselect everything
	function automatic logic [5:0] slotDecode(input logic [2:0] sel);
		logic [5:0] oneHot;
		oneHot = 6'b000000;
		if (sel < 3'd6) begin
			oneHot[sel] = 1'b1;
		end
		return ~oneHot;
	endfunction

	assign wrStb = selStb && !selRw;

	always_comb begin
		readMux = 8'hFF;
		if (selRw) begin
			case (selReg)
				regP1Cnt:   readMux = p1In[7:0];
				regDipSw:   readMux = dipSw;
				// Test button on bit 7, rest pulled up
				regStatusA: readMux = {testBtn, 7'h7F};
				regP2Cnt:   readMux = p2In[7:0];
				// Start/select style lines of both pads
				regStatusB: readMux = {4'hF, p2In[9:8], p1In[9:8]};
				default:    readMux = 8'hFF;
			endcase
		end
	end

	// Bus reply
	always_ff @(posedge clk24M or negedge rstN) begin
		if (!rstN) begin
			rdata <= 8'hFF;
			dtack <= 1'b0;
		end else begin
			dtack <= selStb;
			if (selStb) begin
				rdata <= readMux;
			end
		end
	end

	// Board-side output registers
	always_ff @(posedge clk24M or negedge rstN) begin
		if (!rstN) begin
			p1Out     <= 3'd0;
			p2Out     <= 3'd0;
			cardBank  <= 3'd0;
			slotN     <= `SLOTN_RST;
			ledData   <= '0;
			ledLatchQ <= 3'd0;
			latchFire <= 3'd0;
		end else begin
			latchFire <= 3'd0;
			if (wrStb) begin
				case (selReg)
					regPOutput: begin
						p1Out <= selData[2:0];
						p2Out <= selData[5:3];
					end
					regCrdBank: cardBank <= selData[2:0];
					regSlot:    slotN <= slotDecode(selData[2:0]);
					regLedData: ledData <= selData;
					regLedLatches: begin
						// Only a 0 to 1 step clocks a display
						ledLatchQ <= selData[2:0];
						latchFire <= selData[2:0] & ~ledLatchQ;
					end
					default: ;
				endcase
			end
		end
	end

endmodule

// File: logic/neoBusPkg.sv
`include "neoIo_macros.svh"

package neoBusPkg;

	// Full byte address as driven by the CPU side
	typedef logic [`IO_ADDR_W-1:0] ioAddr_t;

	// Decoded target of one access
	// Latch targets never reach the register file contents
	typedef enum logic [3:0] {
		regP1Cnt,
		regDipSw,
		regStatusA,
		regP2Cnt,
		regStatusB,
		regPOutput,
		regCrdBank,
		regSlot,
		regLedLatches,
		regLedData,
		regCoin,
		regSysLatch,
		regNone
	} ioReg_t;

endpackage

// File: logic/neoIoPkg.sv
package neoIoPkg;

	// EL panel takes 3 data lines
	typedef logic [2:0] elData_t;

	// LED digit driver takes a full byte
	typedef logic [7:0] ledDigit_t;

	// Bit order inside the system latch
	// Index comes from address bits 3:1 of the write
	typedef enum logic [2:0] {
		flagShadow    = 3'd0,
		flagVecN      = 3'd1,
		flagCardWenN  = 3'd2,
		flagCardWenB  = 3'd3,
		flagRegEnN    = 3'd4,
		flagSystemN   = 3'd5,
		flagSramLockN = 3'd6,
		flagPalBank   = 3'd7
	} sysFlag_t;

endpackage

// File: logic/neoIoTop.sv
`include "neoIo_macros.svh"

module neoIoTop (
	input  logic                    clk24M,
	input  logic                    rstN,
	input  logic                    accStb,
	input  neoBusPkg::ioAddr_t      busAddr,
	input  logic                    rw,
	input  logic [`IO_DATA_W-1:0]   wdata,
	input  logic [`JOY_W-1:0]       p1In,
	input  logic [`JOY_W-1:0]       p2In,
	input  logic [`IO_DATA_W-1:0]   dipSw,
	input  logic                    testBtn,
	output logic [`IO_DATA_W-1:0]   rdata,
	output logic                    dtack,
	output logic [2:0]              p1Out,
	output logic [2:0]              p2Out,
	output logic [2:0]              cardBank,
	output logic [5:0]              slotN,
	output logic [3:0]              elOut,
	output logic [8:0]              ledOut1,
	output logic [8:0]              ledOut2,
	output logic                    counter1,
	output logic                    counter2,
	output logic                    lockout1,
	output logic                    lockout2,
	output logic                    shadow,
	output logic                    vecN,
	output logic                    cardWenN,
	output logic                    cardWenB,
	output logic                    regEnN,
	output logic                    systemN,
	output logic                    sramLockN,
	output logic                    palBank
);

	import neoBusPkg::*;
	import neoIoPkg::*;

	logic                   selStb;
	ioReg_t                 selReg;
	logic                   selRw;
	logic [3:0]             selAddr;
	logic [`IO_DATA_W-1:0]  selData;
	logic                   sysLatchWr;
	logic                   coinLatchWr;
	logic [`SYSLATCH_W-1:0] sysQ;
	logic [`COIN_W-1:0]     coinQ;
	ledDigit_t              ledData;
	logic [2:0]             latchFire;
	logic                   elClk;
	logic                   led1Clk;
	logic                   led2Clk;
	elData_t                elData;
	ledDigit_t              led1Data;
	ledDigit_t              led2Data;

	// Bus side, one registered decode stage
	ioAddrDecode uDecode (
		.clk24M      (clk24M),
		.rstN        (rstN),
		.accStb      (accStb),
		.busAddr     (busAddr),
		.rw          (rw),
		.wdata       (wdata),
		.selStb      (selStb),
		.selReg      (selReg),
		.selRw       (selRw),
		.selAddr     (selAddr),
		.selData     (selData),
		.sysLatchWr  (sysLatchWr),
		.coinLatchWr (coinLatchWr)
	);

	ioRegFile uRegFile (
		.clk24M    (clk24M),
		.rstN      (rstN),
		.selStb    (selStb),
		.selReg    (selReg),
		.selRw     (selRw),
		.selData   (selData),
		.p1In      (p1In),
		.p2In      (p2In),
		.dipSw     (dipSw),
		.testBtn   (testBtn),
		.rdata     (rdata),
		.dtack     (dtack),
		.p1Out     (p1Out),
		.p2Out     (p2Out),
		.cardBank  (cardBank),
		.slotN     (slotN),
		.ledData   (ledData),
		.latchFire (latchFire)
	);

	// System latch at 0x3A0001
	addrLatch #(
		.WIDTH   (`SYSLATCH_W),
		.RST_VAL (`SYSLATCH_RST)
	) uSysLatch (
		.clk24M (clk24M),
		.rstN   (rstN),
		.wrStb  (sysLatchWr),
		.wrAddr (selAddr),
		.q      (sysQ)
	);

	// Coin counters and lockouts, all off out of reset
	addrLatch #(
		.WIDTH   (`COIN_W),
		.RST_VAL ('0)
	) uCoinLatch (
		.clk24M (clk24M),
		.rstN   (rstN),
		.wrStb  (coinLatchWr),
		.wrAddr (selAddr),
		.q      (coinQ)
	);

	// EL panel gets the low three bits of the LED data
	displayLatch #(.payloadT(elData_t)) uElLatch (
		.clk24M   (clk24M),
		.rstN     (rstN),
		.fire     (latchFire[0]),
		.payload  (elData_t'(ledData[2:0])),
		.latchClk (elClk),
		.data     (elData)
	);

	displayLatch #(.payloadT(ledDigit_t)) uLed1Latch (
		.clk24M   (clk24M),
		.rstN     (rstN),
		.fire     (latchFire[1]),
		.payload  (ledData),
		.latchClk (led1Clk),
		.data     (led1Data)
	);

	displayLatch #(.payloadT(ledDigit_t)) uLed2Latch (
		.clk24M   (clk24M),
		.rstN     (rstN),
		.fire     (latchFire[2]),
		.payload  (ledData),
		.latchClk (led2Clk),
		.data     (led2Data)
	);

	// Clock on top, data below
	assign elOut   = {elClk, elData};
	assign ledOut1 = {led1Clk, led1Data};
	assign ledOut2 = {led2Clk, led2Data};

	assign counter1 = coinQ[0];
	assign counter2 = coinQ[1];
	assign lockout1 = coinQ[2];
	assign lockout2 = coinQ[3];

	assign shadow    = sysQ[flagShadow];
	assign vecN      = sysQ[flagVecN];
	assign cardWenN  = sysQ[flagCardWenN];
	assign cardWenB  = sysQ[flagCardWenB];
	assign regEnN    = sysQ[flagRegEnN];
	assign systemN   = sysQ[flagSystemN];
	assign sramLockN = sysQ[flagSramLockN];
	assign palBank   = sysQ[flagPalBank];

endmodule

// File: logic/neoIo_macros.svh
`ifndef NEOIO_MACROS_SVH
`define NEOIO_MACROS_SVH

// 68000 byte address, A23 down to A0
`define IO_ADDR_W 24

// Byte lane seen by the I/O registers
`define IO_DATA_W 8

// Joypad lines per player, 4 directions and 6 buttons
`define JOY_W 10

// Coin counter/lockout latch bits
`define COIN_W 4

// System latch bits at 0x3A0001
`define SYSLATCH_W 8

// Cycles the display latch clock stays high
`define LATCH_PULSE_CYCLES 4

// nVEC low after reset, so vectors come from the BIOS
`define SYSLATCH_RST 8'h00

// Slot 0 selected out of reset
`define SLOTN_RST 6'b111110

`endif

// File: runSim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module neoIoTb \
	--Mdir obj_dir -o neoIoSim

# The simulator exits non-zero on a fatal check, the log decides
./obj_dir/neoIoSim > sim.log 2>&1 || true
cat sim.log

if grep -q "^PASS: all tests$" sim.log; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed"
	exit 1
fi

// File: vlog.f
+incdir+logic
logic/neoBusPkg.sv
logic/neoIoPkg.sv
logic/addrLatch.sv
logic/displayLatch.sv
logic/ioAddrDecode.sv
logic/ioRegFile.sv
logic/neoIoTop.sv
dv/neoIoTb.sv
